/* all.f */
cpu_pkg.sv
fetch_ctrl.sv
insn_queue.sv
issue_decoder.sv
reg_file.sv
alu_lane.sv
dual_issue_core.sv
tb_clock.sv
tb_core.sv

/* run.sh */
#!/bin/sh
# Build and run the dual-issue core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_core -f all.f
./obj_dir/Vtb_core | tee sim.log

if grep -qx "Finished with no errors" sim.log; then
   exit 0
else
   exit 1
fi

/* tb_core.sv */
// Testbench top for the dual-issue core; Wishbone memory with a random program and a reference model
module tb_core
   import cpu_pkg::*;
();

   localparam int ADDR_W = 16;
   localparam int MEM_WORDS = 64;
   localparam int TIMEOUT_CYCLES = MEM_WORDS * 8 + 100;
   localparam int DRAIN_CYCLES = 20;

   logic              clk;
   logic              reset;
   logic              wb_cyc;
   logic              wb_stb;
   logic              wb_we;
   logic [ADDR_W-1:0] wb_adr;
   fetch_word_t       wb_dat_r = '0;
   logic              wb_ack = 1'b0;
   commit_t           commit_first;
   commit_t           commit_second;

   fetch_word_t       mem [MEM_WORDS];
   commit_t           exp_q [$];
   int                expected_total;
   int                commits_seen = 0;
   int                errors = 0;
   int                cycles = 0;
   int unsigned       wait_left;
   logic [31:0]       next_adr = '0;
   logic              req_open = 1'b0;
   // Reset as seen by the last rising edge
   logic              reset_seen = 1'b1;

   tb_clock u_clock (
      .clk(clk),
      .reset(reset)
   );

   dual_issue_core #(
      .ADDR_W(ADDR_W)
   ) DUT (
      .clk(clk), .reset(reset),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
      .commit_first(commit_first), .commit_second(commit_second)
   );

   ////////////////////////////////////////
   // Checks
   ////////////////////////////////////////
   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         errors++;
         $display("CHECK FAILED %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   // Commits must come in program order, first port before second
   task automatic check_commit(input string lane, input commit_t c);
      commit_t e;
      if (c.valid !== 1'b1) begin
         return;
      end
      commits_seen++;
      if (exp_q.size() == 0) begin
         errors++;
         $display("Unexpected commit on the %s port: r%0d = %0h, no result was left to commit",
                  lane, c.dest, c.value);
      end else begin
         e = exp_q.pop_front();
         check_value({lane, " commit dest"}, {29'd0, e.dest}, {29'd0, c.dest});
         check_value({lane, " commit value"}, {16'd0, e.value}, {16'd0, c.value});
      end
   endtask

   ////////////////////////////////////////
   // Program and reference model
   ////////////////////////////////////////
   function automatic insn_t make_insn(input logic [4:0] opc, input logic [2:0] rd,
                                       input logic [2:0] rs0, input logic [4:0] low);
      return {opc, rd, rs0, low};
   endfunction

   // Mostly ALU ops, the rest NOPs; r7 shows up as a random rd
   function automatic insn_t random_insn();
      int unsigned pick;
      logic [4:0]  opc;
      pick = $urandom % 8;
      if (pick < 6) begin
         opc = 5'(pick % 4);
      end else begin
         opc = 5'(4 + $urandom % 28);
      end
      return make_insn(opc, 3'($urandom % 8), 3'($urandom % 8), 5'($urandom % 32));
   endfunction

   task automatic fill_memory();
      insn_t lo;
      insn_t hi;
      // Dependent pairs, through rs0 and rs1
      mem[0] = {make_insn(OP_ADD, 3'd2, 3'd1, 5'd0), make_insn(OP_ADDI, 3'd1, 3'd7, 5'd5)};
      mem[1] = {make_insn(OP_SUB, 3'd4, 3'd7, 5'd3), make_insn(OP_SUBI, 3'd3, 3'd2, 5'h1d)};
      // Write to r7 dropped, then r7 read back as zero
      mem[2] = {make_insn(OP_ADD, 3'd5, 3'd7, 5'd1), make_insn(OP_ADD, 3'd7, 3'd1, 5'd2)};
      mem[3] = {make_insn(OP_ADDI, 3'd6, 3'd5, 5'd1), make_insn(5'h1f, 3'd6, 3'd1, 5'd0)};
      for (int w = 4; w < MEM_WORDS; w++) begin
         lo = random_insn();
         hi = random_insn();
         mem[w] = {hi, lo};
      end
   endtask

   // Sequential execution, low half of each word first
   task automatic run_model();
      word_t      regs [8];
      insn_t      insn;
      logic [4:0] opc;
      logic [2:0] rd;
      word_t      a;
      word_t      b;
      word_t      imm;
      word_t      res;
      logic       writes;
      commit_t    c;
      for (int i = 0; i < 8; i++) begin
         regs[i] = '0;
      end
      for (int w = 0; w < MEM_WORDS; w++) begin
         for (int h = 0; h < 2; h++) begin
            insn = (h == 1) ? mem[w][31:16] : mem[w][15:0];
            opc = insn[15:11];
            rd = insn[10:8];
            a = regs[insn[7:5]];
            b = regs[insn[2:0]];
            imm = {{11{insn[4]}}, insn[4:0]};
            writes = 1'b1;
            res = '0;
            case (opc)
               5'd0: res = a + imm;
               5'd1: res = a + b;
               5'd2: res = a - imm;
               5'd3: res = a - b;
               default: writes = 1'b0;
            endcase
            if (rd == 3'd7) begin
               writes = 1'b0;
            end
            if (writes) begin
               regs[rd] = res;
               c.valid = 1'b1;
               c.dest = rd;
               c.value = res;
               exp_q.push_back(c);
            end
         end
      end
      expected_total = exp_q.size();
   endtask

   // Past the program only NOPs
   function automatic fetch_word_t read_word(input logic [31:0] adr);
      if (adr < MEM_WORDS) begin
         return mem[adr[5:0]];
      end
      return 32'hFFFF_FFFF;
   endfunction

   ////////////////////////////////////////
   // Wishbone memory and commit monitor
   ////////////////////////////////////////
   always @(posedge clk) begin
      reset_seen <= reset;
   end

   always @(negedge clk) begin
      if (reset_seen) begin
         check_value("wb_cyc in reset", 32'd0, {31'd0, wb_cyc});
         check_value("commit_first valid in reset", 32'd0, {31'd0, commit_first.valid});
         check_value("commit_second valid in reset", 32'd0, {31'd0, commit_second.valid});
         wb_ack = 1'b0;
         req_open = 1'b0;
      end else begin
         check_commit("first", commit_first);
         check_commit("second", commit_second);
         check_value("wb_we", 32'd0, {31'd0, wb_we});
         check_value("wb_cyc follows wb_stb", {31'd0, wb_stb}, {31'd0, wb_cyc});
         if (wb_ack) begin
            // Word was taken at the last rising edge
            wb_ack = 1'b0;
            check_value("wb_stb low after ack", 32'd0, {31'd0, wb_stb});
         end else begin
            if (req_open) begin
               check_value("wb_stb held until ack", 32'd1, {31'd0, wb_stb});
            end
            if (wb_stb) begin
               check_value("wb_adr", next_adr, {{(32-ADDR_W){1'b0}}, wb_adr});
               if (wait_left == 0) begin
                  wb_dat_r = read_word({{(32-ADDR_W){1'b0}}, wb_adr});
                  wb_ack = 1'b1;
                  req_open = 1'b0;
                  next_adr = next_adr + 32'd1;
                  wait_left = $urandom % 4;
               end else begin
                  wait_left = wait_left - 1;
                  req_open = 1'b1;
               end
            end
         end
      end
   end

   ////////////////////////////////////////
   // Run control
   ////////////////////////////////////////
   initial begin
      // Seeds the run and draws the first wait
      wait_left = $urandom(32'h586d) % 4;
      fill_memory();
      run_model();
      while (exp_q.size() > 0 && cycles < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      if (exp_q.size() > 0) begin
         errors++;
         $display("Timeout after %0d cycles, %0d expected results never committed",
                  cycles, exp_q.size());
         $display("Commits checked: %0d of %0d, errors: %0d",
                  commits_seen, expected_total, errors);
         $display("Finished with errors");
         $finish;
      end else begin
         // Extra cycles catch stray or duplicated commits
         repeat (DRAIN_CYCLES) @(posedge clk);
         check_value("total commit count", expected_total, commits_seen);
         $display("Commits checked: %0d of %0d, errors: %0d",
                  commits_seen, expected_total, errors);
         if (errors == 0) begin
            $display("Finished with no errors");
         end else begin
            $display("Finished with errors");
         end
         $finish;
      end
   end

endmodule

/* tb_clock.sv */
// Testbench clock and reset source; instantiate once in the testbench top
module tb_clock (
   output logic clk,
   output logic reset
);

   // Period of 100 time units
   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Five rising edges in reset, released on a falling edge
   initial begin
      reset = 1'b1;
      repeat (5) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
   end

endmodule

/* dual_issue_core.sv */
// Top level of the dual-issue core: Wishbone instruction fetch in, two commit ports out
module dual_issue_core
   import cpu_pkg::*;
#(
   parameter int ADDR_W = 16
) (
   input  logic              clk,
   input  logic              reset,

   // Instruction fetch bus
   output logic              wb_cyc,
   output logic              wb_stb,
   output logic              wb_we,
   output logic [ADDR_W-1:0] wb_adr,
   input  fetch_word_t       wb_dat_r,
   input  logic              wb_ack,

   // Results, first is older
   output commit_t           commit_first,
   output commit_t           commit_second
);

   logic            room;
   logic            push;
   fetch_word_t     push_word;
   insn_t           head;
   insn_t           next;
   logic [1:0]      avail;
   logic [1:0]      pop_count;
   reg_addr_t [3:0] rd_addr;
   word_t [3:0]     rd_data;
   issue_t          issue_first;
   issue_t          issue_second;

   ////////////////////////////////////////
   // Front end
   ////////////////////////////////////////
   fetch_ctrl #(
      .ADDR_W(ADDR_W)
   ) u_fetch (
      .clk(clk), .reset(reset),
      .room(room), .push(push), .push_word(push_word),
      .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
      .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
   );

   insn_queue u_queue (
      .clk(clk), .reset(reset),
      .push(push), .push_word(push_word),
      .pop_count(pop_count), .head(head), .next(next),
      .avail(avail), .room(room)
   );

   ////////////////////////////////////////
   // Issue, registers and execute
   ////////////////////////////////////////
   issue_decoder u_decoder (
      .clk(clk), .reset(reset),
      .head(head), .next(next), .avail(avail), .pop_count(pop_count),
      .rd_addr(rd_addr), .rd_data(rd_data),
      .issue_first(issue_first), .issue_second(issue_second)
   );

   reg_file u_regs (
      .clk(clk), .reset(reset),
      .rd_addr(rd_addr), .rd_data(rd_data),
      .commit_first(commit_first), .commit_second(commit_second)
   );

   alu_lane u_lane_first (
      .issue(issue_first),
      .commit(commit_first)
   );

   alu_lane u_lane_second (
      .issue(issue_second),
      .commit(commit_second)
   );

endmodule

/* alu_lane.sv */
// One execute lane turning a registered issue slot into a commit in the same cycle
module alu_lane
   import cpu_pkg::*;
(
   input  issue_t  issue,
   output commit_t commit
);

   word_t sum;
   word_t diff;

   ////////////////////////////////////////
   // Arithmetic
   ////////////////////////////////////////

   // Both wrap modulo 2^16
   assign sum = issue.op_a + issue.op_b;
   assign diff = issue.op_a - issue.op_b;

   ////////////////////////////////////////
   // Commit
   ////////////////////////////////////////

   // Valid already excludes NOPs and r7 destinations
   assign commit.valid = issue.valid;
   assign commit.dest = issue.dest;

   always_comb begin
      case (issue.alu_op)
         ALU_SUB: commit.value = diff;
         default: commit.value = sum;
      endcase
   end

endmodule

/* reg_file.sv */
// Eight-entry register file with four forwarded read ports and two commit write ports
module reg_file
   import cpu_pkg::*;
(
   input  logic            clk,
   input  logic            reset,

   input  reg_addr_t [3:0] rd_addr,
   output word_t [3:0]     rd_data,

   input  commit_t         commit_first,
   input  commit_t         commit_second
);

   word_t regs [8];

   ////////////////////////////////////////
   // Read with forwarding
   ////////////////////////////////////////

   // Second lane is younger, so it is checked last and wins
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         rd_data[i] = regs[rd_addr[i]];
         if (commit_first.valid && commit_first.dest == rd_addr[i]) begin
            rd_data[i] = commit_first.value;
         end
         if (commit_second.valid && commit_second.dest == rd_addr[i]) begin
            rd_data[i] = commit_second.value;
         end
         if (rd_addr[i] == ZERO_REG) begin
            rd_data[i] = '0;
         end
      end
   end

   ////////////////////////////////////////
   // Write at the end of the commit cycle
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else begin
         if (commit_first.valid && commit_first.dest != ZERO_REG) begin
            regs[commit_first.dest] <= commit_first.value;
         end
         // Same dest on both lanes keeps the second value
         if (commit_second.valid && commit_second.dest != ZERO_REG) begin
            regs[commit_second.dest] <= commit_second.value;
         end
      end
   end

endmodule

/* issue_decoder.sv */
// Decodes the two oldest queued instructions, pairs them when independent and registers issue slots
module issue_decoder
   import cpu_pkg::*;
(
   input  logic            clk,
   input  logic            reset,

   // Queue side
   input  insn_t           head,
   input  insn_t           next,
   input  logic [1:0]      avail,
   output logic [1:0]      pop_count,

   // Register file, ports 0/1 for head, 2/3 for next
   output reg_addr_t [3:0] rd_addr,
   input  word_t [3:0]     rd_data,

   // Lanes
   output issue_t          issue_first,
   output issue_t          issue_second
);

   issue_t slot_first;
   issue_t slot_second;
   logic   hazard;

   ////////////////////////////////////////
   // Decode helpers
   ////////////////////////////////////////

   // Builds one slot; valid only for ALU ops with a real destination
   function automatic issue_t decode_slot(input insn_t insn, input word_t val0,
                                          input word_t val1);
      issue_t  slot;
      word_t   imm;
      opcode_e opc;
      opc = opcode_e'(insn[OPC_MSB:OPC_LSB]);
      imm = {{(WORD_W-IMM_MSB-1){insn[IMM_MSB]}}, insn[IMM_MSB:0]};
      slot.valid = 1'b0;
      slot.alu_op = ALU_ADD;
      slot.dest = insn[RD_MSB:RD_LSB];
      slot.op_a = val0;
      slot.op_b = val1;
      case (opc)
         OP_ADDI: begin
            slot.valid = 1'b1;
            slot.op_b = imm;
         end
         OP_ADD: slot.valid = 1'b1;
         OP_SUBI: begin
            slot.valid = 1'b1;
            slot.alu_op = ALU_SUB;
            slot.op_b = imm;
         end
         OP_SUB: begin
            slot.valid = 1'b1;
            slot.alu_op = ALU_SUB;
         end
         default: slot.valid = 1'b0;
      endcase
      if (slot.dest == ZERO_REG) begin
         slot.valid = 1'b0;
      end
      return slot;
   endfunction

   // rs0 is read by every ALU op, rs1 only by register forms
   function automatic logic reads_reg(input insn_t insn, input reg_addr_t r);
      opcode_e opc;
      opc = opcode_e'(insn[OPC_MSB:OPC_LSB]);
      case (opc)
         OP_ADDI, OP_SUBI: return insn[RS0_MSB:RS0_LSB] == r;
         OP_ADD, OP_SUB: return (insn[RS0_MSB:RS0_LSB] == r) || (insn[RS1_MSB:RS1_LSB] == r);
         default: return 1'b0;
      endcase
   endfunction

   assign rd_addr[0] = head[RS0_MSB:RS0_LSB];
   assign rd_addr[1] = head[RS1_MSB:RS1_LSB];
   assign rd_addr[2] = next[RS0_MSB:RS0_LSB];
   assign rd_addr[3] = next[RS1_MSB:RS1_LSB];

   assign slot_first = decode_slot(head, rd_data[0], rd_data[1]);
   assign slot_second = decode_slot(next, rd_data[2], rd_data[3]);

   // Only a writing first instruction can block the second
   assign hazard = slot_first.valid && reads_reg(next, slot_first.dest);

   // NOPs are popped as well, they just issue with valid low
   always_comb begin
      case (avail)
         2'd0: pop_count = 2'd0;
         2'd1: pop_count = 2'd1;
         default: pop_count = hazard ? 2'd1 : 2'd2;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         issue_first <= '0;
         issue_second <= '0;
      end else begin
         issue_first <= slot_first;
         issue_first.valid <= slot_first.valid && (pop_count != 2'd0);
         issue_second <= slot_second;
         issue_second.valid <= slot_second.valid && (pop_count == 2'd2);
      end
   end

endmodule

/* insn_queue.sv */
// Four-entry halfword instruction queue between fetch and the issue decoder
module insn_queue
   import cpu_pkg::*;
(
   input  logic        clk,
   input  logic        reset,

   // From fetch
   input  logic        push,
   input  fetch_word_t push_word,

   // To and from the decoder
   input  logic [1:0]  pop_count,
   output insn_t       head,
   output insn_t       next,
   output logic [1:0]  avail,

   // Space for one more fetched word
   output logic        room
);

   insn_t      slots [4];
   logic [1:0] rd_ptr;
   logic [1:0] rd_ptr_next;
   logic [1:0] wr_ptr;
   logic [1:0] wr_ptr_hi;
   // Occupancy, 0 to 4
   logic [2:0] count;
   logic [2:0] count_after_pop;

   assign rd_ptr_next = rd_ptr + 2'd1;
   assign wr_ptr_hi = wr_ptr + 2'd1;
   assign count_after_pop = count - {1'b0, pop_count};

   ////////////////////////////////////////
   // Decoder view
   ////////////////////////////////////////
   assign head = slots[rd_ptr];
   assign next = slots[rd_ptr_next];
   assign avail = (count >= 3'd2) ? 2'd2 : count[1:0];

   // Fetch may start only if two halves still fit after this pop
   assign room = (count_after_pop <= 3'd2);

   ////////////////////////////////////////
   // Pointers and count
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count <= '0;
      end else begin
         rd_ptr <= rd_ptr + pop_count;
         if (push) begin
            wr_ptr <= wr_ptr + 2'd2;
            count <= count_after_pop + 3'd2;
         end else begin
            count <= count_after_pop;
         end
      end
   end

   // Low half is the older instruction
   always_ff @(posedge clk) begin
      if (push) begin
         slots[wr_ptr] <= push_word[WORD_W-1:0];
         slots[wr_ptr_hi] <= push_word[2*WORD_W-1:WORD_W];
      end
   end

endmodule

/* fetch_ctrl.sv */
// Wishbone classic read master that fetches instruction words into the instruction queue
module fetch_ctrl
   import cpu_pkg::*;
#(
   parameter int ADDR_W = 16
) (
   input  logic              clk,
   input  logic              reset,

   // Queue side
   input  logic              room,
   output logic              push,
   output fetch_word_t       push_word,

   // Wishbone master
   output logic              wb_cyc,
   output logic              wb_stb,
   output logic              wb_we,
   output logic [ADDR_W-1:0] wb_adr,
   input  fetch_word_t       wb_dat_r,
   input  logic              wb_ack
);

   fetch_state_e      state;
   // Word address of the next read
   logic [ADDR_W-1:0] pc;

   ////////////////////////////////////////
   // Request state machine
   ////////////////////////////////////////

   // A request only starts when the queue can take a whole word,
   // then holds until ack. Going back through IDLE leaves one
   // cycle with cyc low between reads
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= FETCH_IDLE;
         pc <= '0;
      end else begin
         case (state)
            FETCH_IDLE: begin
               if (room) begin
                  state <= FETCH_WAIT;
               end
            end
            FETCH_WAIT: begin
               if (wb_ack) begin
                  state <= FETCH_IDLE;
                  pc <= pc + 1'b1;
               end
            end
            default: begin
               state <= FETCH_IDLE;
            end
         endcase
      end
   end

   ////////////////////////////////////////
   // Bus and queue outputs
   ////////////////////////////////////////
   assign wb_cyc = (state == FETCH_WAIT);
   assign wb_stb = (state == FETCH_WAIT);
   // Read only port
   assign wb_we = 1'b0;
   assign wb_adr = pc;

   // Word goes to the queue in the ack cycle itself
   assign push = (state == FETCH_WAIT) && wb_ack;
   assign push_word = wb_dat_r;

endmodule

/* cpu_pkg.sv */
// Shared types, encodings and field positions for the dual-issue core; import where needed
package cpu_pkg;

   ////////////////////////////////////////
   // Widths and basic types
   ////////////////////////////////////////
   localparam int WORD_W = 16;
   localparam int REG_W = 3;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [WORD_W-1:0] insn_t;
   typedef logic [2*WORD_W-1:0] fetch_word_t;
   typedef logic [REG_W-1:0] reg_addr_t;

   // Never written, always reads as zero
   localparam reg_addr_t ZERO_REG = 3'd7;

   ////////////////////////////////////////
   // Instruction fields
   ////////////////////////////////////////
   localparam int OPC_MSB = 15;
   localparam int OPC_LSB = 11;
   localparam int RD_MSB = 10;
   localparam int RD_LSB = 8;
   localparam int RS0_MSB = 7;
   localparam int RS0_LSB = 5;
   localparam int RS1_MSB = 2;
   localparam int RS1_LSB = 0;
   // Immediate starts at bit 0, sign bit is IMM_MSB
   localparam int IMM_MSB = 4;

   // Anything outside these four is a NOP
   typedef enum logic [4:0] {
      OP_ADDI = 5'b00000,
      OP_ADD  = 5'b00001,
      OP_SUBI = 5'b00010,
      OP_SUB  = 5'b00011
   } opcode_e;

   typedef enum logic {
      ALU_ADD = 1'b0,
      ALU_SUB = 1'b1
   } alu_op_e;

   // Fetch bus state
   typedef enum logic {
      FETCH_IDLE = 1'b0,
      FETCH_WAIT = 1'b1
   } fetch_state_e;

   ////////////////////////////////////////
   // Pipeline structs
   ////////////////////////////////////////
   typedef struct packed {
      logic      valid;
      alu_op_e   alu_op;
      reg_addr_t dest;
      word_t     op_a;
      word_t     op_b;
   } issue_t;

   typedef struct packed {
      logic      valid;
      reg_addr_t dest;
      word_t     value;
   } commit_t;

endpackage
